//--- Bender.yml
package:
  name: clk_diag

sources:
  - common/clkDiagPkg.sv
  - common/clkCtlPkg.sv
  - rtl/diagCmdQueue.sv
  - clkCtl/clkFuncExec.sv
  - clkCtl/clkPulseGen.sv
  - rtl/diagRespPort.sv
  - rtl/clkDiagTop.sv
  - target: test
    files:
      - verification/clkDiagChecker.sv
      - verification/clkDiagTb.sv

//--- build.f
common/clkDiagPkg.sv
common/clkCtlPkg.sv
rtl/diagCmdQueue.sv
clkCtl/clkFuncExec.sv
clkCtl/clkPulseGen.sv
rtl/diagRespPort.sv
rtl/clkDiagTop.sv
verification/clkDiagChecker.sv
verification/clkDiagTb.sv

//--- clkCtl/clkFuncExec.sv
`timescale 1ns/1ps

module clkFuncExec import clkDiagPkg::*, clkCtlPkg::*; (
  input  logic      masterClk,
  input  logic      rstN,
  input  logic      qValid,
  input  diagFunc   qFunc,
  input  diagData   qData,
  output logic      qPop,
  output clkMode    modeReq,
  output logic      modeLoad,
  output clkRate    rate,
  output burstCount burstLoadValue,
  input  logic      running,
  input  burstCount burstRemaining,
  output logic      eboxReset,
  output logic      statusValid,
  output statusWord statusData,
  input  logic      slotFree
);

  logic errFlag;
  logic statusStall;

  // A status read waits until the response slot is empty
  assign statusStall = qValid && (qFunc == fnReadStatus) && !slotFree;
  assign qPop        = qValid && !statusStall;

  // Mode requests go straight to the pulse generator in the execute cycle
  always_comb begin
    modeReq     = modeIdle;
    modeLoad    = 1'b0;
    statusValid = 1'b0;
    if (qPop) begin
      case (qFunc)
        fnStop: begin
          modeReq  = modeIdle;
          modeLoad = 1'b1;
        end
        fnStart: begin
          modeReq  = modeRun;
          modeLoad = 1'b1;
        end
        fnStep: begin
          modeReq  = modeStep;
          modeLoad = 1'b1;
        end
        fnBurst: begin
          modeReq  = modeBurst;
          modeLoad = 1'b1;
        end
        fnReadStatus: statusValid = 1'b1;
        default: modeLoad = 1'b0;
      endcase
    end
  end

  // Status snapshot taken as the read executes
  always_comb begin
    statusData = '0;
    statusData[stRunningBit]        = running;
    statusData[stResetBit]          = eboxReset;
    statusData[stErrBit]            = errFlag;
    statusData[stRateHi:stRateLo]   = rate;
    statusData[stBurstHi:stBurstLo] = burstRemaining;
  end

  // Held registers, each updated by its own function
  always_ff @(posedge masterClk or negedge rstN) begin
    if (!rstN) begin
      // EBOX comes out of reset held in reset
      eboxReset      <= 1'b1;
      errFlag        <= 1'b0;
      rate           <= '0;
      burstLoadValue <= '0;
    end else if (qPop) begin
      case (qFunc)
        fnClrReset:       eboxReset <= 1'b0;
        fnSetReset:       eboxReset <= 1'b1;
        // Low nibble first, as the front end loads it
        fnLoadBurstRight: burstLoadValue[3:0] <= qData[3:0];
        fnLoadBurstLeft:  burstLoadValue[7:4] <= qData[3:0];
        fnSetRate:        rate <= qData[1:0];
        fnClrErr:         errFlag <= 1'b0;
        // Handled by the mode and status logic above
        fnStop, fnStart, fnStep, fnBurst, fnReadStatus: errFlag <= errFlag;
        // Anything undefined flags an error
        default:          errFlag <= 1'b1;
      endcase
    end
  end

endmodule

//--- clkCtl/clkPulseGen.sv
`timescale 1ns/1ps

module clkPulseGen import clkCtlPkg::*; (
  input  logic      masterClk,
  input  logic      rstN,
  input  clkMode    modeReq,
  input  logic      modeLoad,
  input  clkRate    rate,
  input  burstCount burstLoadValue,
  output logic      eboxClkEn,
  output logic      running,
  output burstCount burstRemaining
);

  clkMode              state;
  logic [divWidth-1:0] divCnt;
  logic [divWidth-1:0] lastCnt;
  logic                periodEnd;

  // Last count of a period is 2**rate - 1
  assign lastCnt = divWidth'((4'd1 << rate) - 4'd1);

  // Compare with >= so a rate lowered mid period still ends it
  assign periodEnd = (state != modeIdle) && (divCnt >= lastCnt);

  // A load in the same cycle cancels the pulse, so fnStop adds none
  assign eboxClkEn = periodEnd && !modeLoad;
  assign running   = (state != modeIdle);

  always_ff @(posedge masterClk or negedge rstN) begin
    if (!rstN) begin
      state          <= modeIdle;
      divCnt         <= '0;
      burstRemaining <= '0;
    end else if (modeLoad) begin
      // Each load restarts the period from zero
      divCnt <= '0;
      if (modeReq == modeBurst) begin
        burstRemaining <= burstLoadValue;
        // Zero burst never leaves idle
        state <= (burstLoadValue == '0) ? modeIdle : modeBurst;
      end else begin
        state <= modeReq;
      end
    end else if (periodEnd) begin
      divCnt <= '0;
      case (state)
        modeStep: state <= modeIdle;
        modeBurst: begin
          burstRemaining <= burstRemaining - 1'b1;
          if (burstRemaining == 8'd1) begin
            state <= modeIdle;
          end
        end
        default: state <= state;
      endcase
    end else if (state != modeIdle) begin
      // Idle is only entered with the divider at zero
      divCnt <= divCnt + 1'b1;
    end
  end

endmodule

//--- common/clkCtlPkg.sv
package clkCtlPkg;

  // Clock generator modes
  typedef enum logic [1:0] {
    // No pulses
    modeIdle,
    // Pulse every rate period until the next load
    modeRun,
    // One period, one pulse, then idle
    modeStep,
    // Pulse until the burst counter runs out
    modeBurst
  } clkMode;

  // Rate select, period is 2**rate masterClk cycles
  typedef logic [1:0] clkRate;

  // Burst counter, loaded as two nibbles
  typedef logic [7:0] burstCount;

  // Widest divider count, covers the longest period
  localparam int divWidth = 3;

endpackage

//--- common/clkDiagPkg.sv
package clkDiagPkg;

  // CLK diagnostic function codes, octal as the front end numbers them
  typedef enum logic [5:0] {
    // Clock mode control
    fnStop           = 6'o00,
    fnStart          = 6'o01,
    fnStep           = 6'o02,
    fnBurst          = 6'o03,
    // EBOX reset line
    fnClrReset       = 6'o06,
    fnSetReset       = 6'o07,
    // Burst counter nibbles, right is low
    fnLoadBurstRight = 6'o42,
    fnLoadBurstLeft  = 6'o43,
    // Clock rate select
    fnSetRate        = 6'o44,
    // Clear the parity error flag
    fnClrErr         = 6'o46,
    // Return one status word to the front end
    fnReadStatus     = 6'o76
  } diagFunc;

  // Data byte that travels with each function
  typedef logic [7:0] diagData;

  // Status word returned on fnReadStatus
  typedef logic [15:0] statusWord;

  // Status word field positions
  localparam int stRunningBit = 15;
  localparam int stResetBit   = 14;
  localparam int stErrBit     = 13;
  localparam int stRateHi     = 12;
  localparam int stRateLo     = 11;
  localparam int stBurstHi    = 7;
  localparam int stBurstLo    = 0;

endpackage

//--- rtl/clkDiagTop.sv
`timescale 1ns/1ps

module clkDiagTop import clkDiagPkg::*, clkCtlPkg::*; #(
  parameter int cmdDepth       = 4,
  parameter int respCreditInit = 2
) (
  input  logic      masterClk,
  input  logic      rstN,
  input  logic      cmdValid,
  input  diagFunc   cmdFunc,
  input  diagData   cmdData,
  output logic      cmdCreditReturn,
  output logic      eboxReset,
  output logic      eboxClkEn,
  output logic      respValid,
  output statusWord respData,
  input  logic      respCreditReturn
);

  // Queue head to executor
  logic      qValid;
  diagFunc   qFunc;
  diagData   qData;
  logic      qPop;

  // Executor to pulse generator
  clkMode    modeReq;
  logic      modeLoad;
  clkRate    rate;
  burstCount burstLoadValue;
  logic      running;
  burstCount burstRemaining;

  // Executor to response port
  logic      statusValid;
  statusWord statusData;
  logic      slotFree;

  diagCmdQueue #(
    .cmdDepth(cmdDepth)
  ) uCmdQueue (
    .masterClk      (masterClk),
    .rstN           (rstN),
    .cmdValid       (cmdValid),
    .cmdFunc        (cmdFunc),
    .cmdData        (cmdData),
    .qPop           (qPop),
    .qValid         (qValid),
    .qFunc          (qFunc),
    .qData          (qData),
    .cmdCreditReturn(cmdCreditReturn)
  );

  // clkCtl executor
  clkFuncExec uFuncExec (
    .masterClk     (masterClk),
    .rstN          (rstN),
    .qValid        (qValid),
    .qFunc         (qFunc),
    .qData         (qData),
    .qPop          (qPop),
    .modeReq       (modeReq),
    .modeLoad      (modeLoad),
    .rate          (rate),
    .burstLoadValue(burstLoadValue),
    .running       (running),
    .burstRemaining(burstRemaining),
    .eboxReset     (eboxReset),
    .statusValid   (statusValid),
    .statusData    (statusData),
    .slotFree      (slotFree)
  );

  // clkCtl pulse generator
  clkPulseGen uPulseGen (
    .masterClk     (masterClk),
    .rstN          (rstN),
    .modeReq       (modeReq),
    .modeLoad      (modeLoad),
    .rate          (rate),
    .burstLoadValue(burstLoadValue),
    .eboxClkEn     (eboxClkEn),
    .running       (running),
    .burstRemaining(burstRemaining)
  );

  diagRespPort #(
    .respCreditInit(respCreditInit)
  ) uRespPort (
    .masterClk       (masterClk),
    .rstN            (rstN),
    .statusValid     (statusValid),
    .statusData      (statusData),
    .slotFree        (slotFree),
    .respValid       (respValid),
    .respData        (respData),
    .respCreditReturn(respCreditReturn)
  );

endmodule

//--- rtl/diagCmdQueue.sv
`timescale 1ns/1ps

module diagCmdQueue import clkDiagPkg::*; #(
  parameter int cmdDepth = 4
) (
  input  logic    masterClk,
  input  logic    rstN,
  input  logic    cmdValid,
  input  diagFunc cmdFunc,
  input  diagData cmdData,
  input  logic    qPop,
  output logic    qValid,
  output diagFunc qFunc,
  output diagData qData,
  output logic    cmdCreditReturn
);

  // Pointer needs at least one bit even for a single entry
  localparam int ptrWidth = (cmdDepth > 1) ? $clog2(cmdDepth) : 1;
  localparam int cntWidth = $clog2(cmdDepth + 1);
  localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(cmdDepth - 1);

  diagFunc funcMem [cmdDepth];
  diagData dataMem [cmdDepth];

  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [cntWidth-1:0] count;
  logic                doPop;

  // Head entry is always on the outputs
  assign qValid = (count != '0);
  assign qFunc  = funcMem[rdPtr];
  assign qData  = dataMem[rdPtr];

  // Pop only counts when something is there
  assign doPop = qPop && qValid;

  // Storage write, front end never sends without a credit
  always_ff @(posedge masterClk) begin
    if (cmdValid) begin
      funcMem[wrPtr] <= cmdFunc;
      dataMem[wrPtr] <= cmdData;
    end
  end

  always_ff @(posedge masterClk or negedge rstN) begin
    if (!rstN) begin
      wrPtr           <= '0;
      rdPtr           <= '0;
      count           <= '0;
      cmdCreditReturn <= 1'b0;
    end else begin
      if (cmdValid) begin
        wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
      end
      // Occupancy, push and pop may land together
      count <= count + cntWidth'(cmdValid) - cntWidth'(doPop);
      // One credit back per dequeue, a cycle later
      cmdCreditReturn <= doPop;
    end
  end

endmodule

//--- rtl/diagRespPort.sv
`timescale 1ns/1ps

module diagRespPort import clkDiagPkg::*; #(
  parameter int respCreditInit = 2
) (
  input  logic      masterClk,
  input  logic      rstN,
  input  logic      statusValid,
  input  statusWord statusData,
  output logic      slotFree,
  output logic      respValid,
  output statusWord respData,
  input  logic      respCreditReturn
);

  // Receiver never returns more than it was given
  localparam int credWidth = $clog2(respCreditInit + 1);

  logic [credWidth-1:0] credits;
  logic                 holdValid;
  statusWord            holdData;

  // Send the held word whenever a credit is available
  assign respValid = holdValid && (credits != '0);
  assign respData  = holdData;

  // Slot can refill in the same cycle it drains
  assign slotFree = !holdValid || respValid;

  // Payload register, loaded only into a free slot
  always_ff @(posedge masterClk) begin
    if (statusValid && slotFree) begin
      holdData <= statusData;
    end
  end

  always_ff @(posedge masterClk or negedge rstN) begin
    if (!rstN) begin
      holdValid <= 1'b0;
      credits   <= credWidth'(respCreditInit);
    end else begin
      if (statusValid && slotFree) begin
        holdValid <= 1'b1;
      end else if (respValid) begin
        holdValid <= 1'b0;
      end
      // Returns add, sends spend
      credits <= credits + credWidth'(respCreditReturn) - credWidth'(respValid);
    end
  end

endmodule

//--- verification/clkDiagChecker.sv
`timescale 1ns/1ps

module clkDiagChecker import clkDiagPkg::*; (
  input logic      masterClk,
  input logic      rstN,
  input logic      cmdValid,
  input logic      cmdCreditReturn,
  input logic      eboxReset,
  input logic      eboxClkEn,
  input logic      respValid,
  input statusWord respData
);

  // Status words still due on respData, oldest first
  statusWord expQ[$];
  statusWord expWord;

  int cycle        = 0;
  int lastPulse    = 0;
  int windowPulses = 0;
  int minGap       = 0;
  int maxGap       = 0;
  int gap          = 0;
  int sentCount    = 0;
  int returnCount  = 0;
  int respCount    = 0;
  int testCount    = 0;
  int errCount     = 0;

  // One line per compared value
  task automatic compareValue(input string what, input logic [15:0] expVal,
                              input logic [15:0] gotVal);
    testCount++;
    if (expVal !== gotVal) begin
      errCount++;
      $display("[FAIL] test %0d %s expected %h got %h", testCount, what, expVal, gotVal);
    end else begin
      $display("[PASS] test %0d %s %h", testCount, what, gotVal);
    end
  endtask

  // Outputs were driven on the falling edge, so sample on the rising one
  always @(posedge masterClk) begin
    cycle = cycle + 1;
    if (rstN) begin
      if (cmdValid) begin
        sentCount++;
      end
      if (cmdCreditReturn) begin
        returnCount++;
      end
      // Track the spread of pulse spacing inside the current window
      if (eboxClkEn) begin
        if (windowPulses > 0) begin
          gap = cycle - lastPulse;
          if (windowPulses == 1 || gap < minGap) begin
            minGap = gap;
          end
          if (windowPulses == 1 || gap > maxGap) begin
            maxGap = gap;
          end
        end
        lastPulse = cycle;
        windowPulses++;
      end
      if (respValid) begin
        respCount++;
        if (expQ.size() == 0) begin
          testCount++;
          errCount++;
          $display("Status word %h arrived on respData when none was expected", respData);
        end else begin
          expWord = expQ.pop_front();
          compareValue("respData", expWord, respData);
        end
      end
    end
  end

  // Count of ff skips the count, spacing of zero skips the spacing
  task automatic checkPulses(input logic [7:0] expCount, input logic [7:0] expSpacing);
    if (expCount != 8'hff) begin
      compareValue("eboxClkEn count", 16'(expCount), 16'(windowPulses));
    end
    if (expSpacing != 8'h00 && windowPulses >= 2) begin
      compareValue("eboxClkEn min spacing", 16'(expSpacing), 16'(minGap));
      compareValue("eboxClkEn max spacing", 16'(expSpacing), 16'(maxGap));
    end
    // Next window starts clean
    windowPulses = 0;
  endtask

  task automatic checkReset(input logic expVal);
    compareValue("eboxReset", 16'(expVal), 16'(eboxReset));
  endtask

  // Commands not yet credited back, and responses seen so far
  task automatic checkCredits(input logic [7:0] expOutstanding, input logic [7:0] expResp);
    compareValue("outstanding commands", 16'(expOutstanding), 16'(sentCount - returnCount));
    compareValue("respValid count", 16'(expResp), 16'(respCount));
  endtask

  task automatic expectStatus(input statusWord expVal);
    expQ.push_back(expVal);
  endtask

  function automatic int pendingStatus();
    return expQ.size();
  endfunction

  task automatic report();
    $display("Tests %0d, passed %0d, failed %0d, commands %0d, credits back %0d, responses %0d",
             testCount, testCount - errCount, errCount, sentCount, returnCount, respCount);
  endtask

endmodule

//--- verification/clkDiagTb.sv
`timescale 1ns/1ps

module clkDiagTb import clkDiagPkg::*; ();

  localparam int cmdDepth       = 4;
  localparam int respCreditInit = 2;
  localparam int maxRecords     = 128;
  localparam int waitLimit      = 500;

  // Record types in the data file
  localparam logic [7:0] recCommand = 8'h01;
  localparam logic [7:0] recPause   = 8'h02;
  localparam logic [7:0] recPulses  = 8'h03;
  localparam logic [7:0] recStatus  = 8'h04;
  localparam logic [7:0] recHold    = 8'h05;
  localparam logic [7:0] recReset   = 8'h06;
  localparam logic [7:0] recCredits = 8'h07;
  localparam logic [7:0] recEnd     = 8'hff;

  logic      masterClk        = 1'b0;
  logic      rstN             = 1'b0;
  logic      cmdValid         = 1'b0;
  diagFunc   cmdFunc          = fnStop;
  diagData   cmdData          = '0;
  logic      respCreditReturn = 1'b0;
  logic      cmdCreditReturn;
  logic      eboxReset;
  logic      eboxClkEn;
  logic      respValid;
  statusWord respData;

  // Type, function, data, expected
  logic [39:0] records [maxRecords];

  int   cmdSeed     = 32'hbadb;
  int   credSeed    = 32'hbadb;
  int   sentCount   = 0;
  int   returnsSeen = 0;
  int   respSeen    = 0;
  int   creditsBack = 0;
  int   retDelay    = 0;
  logic holdCredits = 1'b0;
  logic holdSampled = 1'b0;
  logic runAborted  = 1'b0;

  always #5 masterClk = ~masterClk;

  clkDiagTop #(
    .cmdDepth      (cmdDepth),
    .respCreditInit(respCreditInit)
  ) u_dut (
    .masterClk       (masterClk),
    .rstN            (rstN),
    .cmdValid        (cmdValid),
    .cmdFunc         (cmdFunc),
    .cmdData         (cmdData),
    .cmdCreditReturn (cmdCreditReturn),
    .eboxReset       (eboxReset),
    .eboxClkEn       (eboxClkEn),
    .respValid       (respValid),
    .respData        (respData),
    .respCreditReturn(respCreditReturn)
  );

  clkDiagChecker uChecker (
    .masterClk      (masterClk),
    .rstN           (rstN),
    .cmdValid       (cmdValid),
    .cmdCreditReturn(cmdCreditReturn),
    .eboxReset      (eboxReset),
    .eboxClkEn      (eboxClkEn),
    .respValid      (respValid),
    .respData       (respData)
  );

  // Front end side counters, read back on the falling edge
  always @(posedge masterClk) begin
    holdSampled <= holdCredits;
    if (cmdCreditReturn) begin
      returnsSeen <= returnsSeen + 1;
    end
    if (respValid) begin
      respSeen <= respSeen + 1;
    end
  end

  // Receiver gives one credit back per response after a random delay
  always @(negedge masterClk) begin
    respCreditReturn = 1'b0;
    if (rstN && !holdSampled && creditsBack < respSeen) begin
      if (retDelay > 0) begin
        retDelay = retDelay - 1;
      end else begin
        respCreditReturn = 1'b1;
        creditsBack      = creditsBack + 1;
        retDelay         = $unsigned($random(credSeed)) % 4;
      end
    end
  end

  // One function per credit, then a random idle gap
  task automatic sendCommand(input logic [5:0] func, input diagData data);
    int waited;
    int gapCycles;
    waited = 0;
    while (cmdDepth - sentCount + returnsSeen <= 0 && !runAborted) begin
      @(negedge masterClk);
      waited++;
      if (waited > waitLimit) begin
        $display("Timeout: no command credit came back within %0d cycles", waitLimit);
        runAborted = 1'b1;
      end
    end
    if (!runAborted) begin
      cmdValid = 1'b1;
      cmdFunc  = diagFunc'(func);
      cmdData  = data;
      sentCount++;
      @(negedge masterClk);
      cmdValid  = 1'b0;
      gapCycles = $unsigned($random(cmdSeed)) % 4;
      repeat (gapCycles) @(negedge masterClk);
    end
  endtask

  initial begin
    int          idx;
    int          waited;
    logic [39:0] rec;
    logic        done;
    $readmemh("verification/clkDiag_testdata.hex", records);
    repeat (4) @(negedge masterClk);
    rstN = 1'b1;
    @(negedge masterClk);
    idx  = 0;
    done = 1'b0;
    while (!done && !runAborted) begin
      rec = records[idx];
      case (rec[39:32])
        recCommand: sendCommand(rec[29:24], rec[23:16]);
        recPause:   repeat (rec[23:16]) @(negedge masterClk);
        recPulses:  uChecker.checkPulses(rec[15:8], rec[7:0]);
        recStatus: begin
          // Expected word queued before the read can answer
          uChecker.expectStatus(rec[15:0]);
          sendCommand(fnReadStatus, 8'h00);
        end
        recHold:    holdCredits = rec[16];
        recReset:   uChecker.checkReset(rec[0]);
        recCredits: uChecker.checkCredits(rec[15:8], rec[7:0]);
        recEnd:     done = 1'b1;
        default: begin
          $display("Record %0d has unknown type %h, data file is broken", idx, rec[39:32]);
          runAborted = 1'b1;
        end
      endcase
      idx++;
      if (idx >= maxRecords) begin
        done = 1'b1;
      end
    end
    // Let the last responses drain
    waited = 0;
    while (uChecker.pendingStatus() != 0 && !runAborted) begin
      @(negedge masterClk);
      waited++;
      if (waited > waitLimit) begin
        $display("Timeout: %0d status words never arrived", uChecker.pendingStatus());
        runAborted = 1'b1;
      end
    end
    uChecker.report();
    if (runAborted || uChecker.errCount != 0) begin
      $display("Checks failed");
    end else begin
      $display("All checks passed");
    end
    $finish;
  end

endmodule

//--- verification/clkDiag_testdata.hex
// Columns: type_func_data_expected, function code and data are bytes, expected is 16 bits
// Types: 01 command, 02 pause cycles, 03 pulse count_spacing, 04 status read, 05 hold, 06 reset, 07 outstanding_responses, ff end
06_00_00_0001
02_00_08_0000
03_00_00_0000
07_00_00_0000
01_06_00_0000
02_00_04_0000
06_00_00_0000
01_07_00_0000
02_00_04_0000
06_00_00_0001
01_02_00_0000
02_00_10_0000
03_00_00_0100
01_22_02_0000
01_23_01_0000
01_03_00_0000
02_00_28_0000
03_00_00_1201
01_24_01_0000
01_23_00_0000
01_22_03_0000
01_03_00_0000
02_00_28_0000
03_00_00_0302
01_24_02_0000
01_03_00_0000
02_00_28_0000
03_00_00_0304
01_24_03_0000
01_03_00_0000
02_00_30_0000
03_00_00_0308
01_22_00_0000
01_03_00_0000
02_00_10_0000
03_00_00_0000
01_01_00_0000
02_00_14_0000
04_00_00_d800
03_00_00_ff08
01_00_00_0000
02_00_08_0000
03_00_00_ff08
02_00_14_0000
03_00_00_0000
04_00_00_5800
01_05_00_0000
04_00_00_7800
01_26_00_0000
04_00_00_5800
02_00_10_0000
07_00_00_0004
05_00_01_0000
04_00_00_5800
04_00_00_5800
04_00_00_5800
04_00_00_5800
01_26_00_0000
01_26_00_0000
01_26_00_0000
02_00_0a_0000
07_00_00_0406
05_00_00_0000
02_00_1e_0000
07_00_00_0008
ff_00_00_0000
